// File: Bender.yml
package:
  name: app_top

export_include_dirs:
  - common

sources:
  - files:
      - common/lb_pkg.sv
      - common/periph_pkg.sv
      - common/lb_if.sv
      - src/data_ram.sv
      - src/pio.sv
      - src/tmr.sv
      - src/lb_mux.sv
      - src/app_top.sv
  - target: test
    files:
      - testbench/app_checker.sv
      - testbench/app_top_tb.sv

// File: app_top.f
+incdir+common
common/lb_pkg.sv
common/periph_pkg.sv
common/lb_if.sv
src/data_ram.sv
src/pio.sv
src/tmr.sv
src/lb_mux.sv
src/app_top.sv
testbench/app_checker.sv
testbench/app_top_tb.sv

// File: common/lb_config.svh
// Bus widths, memory depth, timer beat and version constants shared by packages and RTL
`ifndef LB_CONFIG_SVH
`define LB_CONFIG_SVH

// Data bus width in bits
`define LB_DAT_WIDTH 32

// Local bus word address, top two bits pick the port
`define LB_ADR_WIDTH 18

// Data RAM word address width
`define RAM_ADR_WIDTH 10

// Clock cycles per timer tick
`define TMR_BEAT 4

// Hardware version
`define HW_VER_MAJOR 1
`define HW_VER_MINOR 0

// Parallel I/O width
`define PIO_WIDTH 16

`endif

// File: common/lb_if.sv
// Local bus connection between the multiplexer and its ports, address type set per instance
`default_nettype none
`timescale 1ns/1ps

interface lb_if
#(
    // Port address by default, full local bus address upstream of the mux
    parameter type adr_t = lb_pkg::port_adr_t
);

    // Word address
    adr_t              adr;
    // Single cycle strobes
    logic              wr;
    logic              rd;
    // Write data
    lb_pkg::bus_dat_t  din;
    // Read data, valid with vld one cycle after rd
    lb_pkg::bus_dat_t  dout;
    logic              vld;

    // Requester side
    modport master (output adr, wr, rd, din, input dout, vld);

    // Responder side
    modport slave (input adr, wr, rd, din, output dout, vld);

endinterface

`default_nettype wire

// File: common/lb_pkg.sv
// Bus types for the master port, the local bus and the data RAM, used by all RTL blocks
`default_nettype none

`include "lb_config.svh"

package lb_pkg;

    // Master side byte address
    typedef logic [31:0] bus_adr_t;

    // One data word
    typedef logic [`LB_DAT_WIDTH-1:0] bus_dat_t;

    // One strobe per byte lane
    typedef logic [`LB_DAT_WIDTH/8-1:0] bus_strb_t;

    // Local bus word address before the port split
    typedef logic [`LB_ADR_WIDTH-1:0] lb_adr_t;

    // Address inside a single port
    typedef logic [`LB_ADR_WIDTH-3:0] port_adr_t;

    // RAM word index
    typedef logic [`RAM_ADR_WIDTH-1:0] ram_adr_t;

endpackage

`default_nettype wire

// File: common/periph_pkg.sv
// Peripheral data types and register offsets for the parallel I/O and timer blocks
`default_nettype none

`include "lb_config.svh"

package periph_pkg;

    // Parallel I/O word
    typedef logic [`PIO_WIDTH-1:0] pio_dat_t;

    // Timer count and period
    typedef logic [31:0] tmr_cnt_t;

    // PIO register map
    localparam lb_pkg::port_adr_t PIO_VERSION = 'd0;
    localparam lb_pkg::port_adr_t PIO_OUT     = 'd1;
    localparam lb_pkg::port_adr_t PIO_IN      = 'd2;
    localparam lb_pkg::port_adr_t PIO_SET     = 'd3;
    localparam lb_pkg::port_adr_t PIO_CLR     = 'd4;

    // Timer register map
    localparam lb_pkg::port_adr_t TMR_CTL    = 'd0;
    localparam lb_pkg::port_adr_t TMR_PERIOD = 'd1;
    localparam lb_pkg::port_adr_t TMR_COUNT  = 'd2;
    localparam lb_pkg::port_adr_t TMR_STA    = 'd3;

endpackage

`default_nettype wire

// File: src/app_top.sv
// Application top: splits master accesses between data RAM and local bus and merges read data
`default_nettype none
`timescale 1ns/1ps

`include "lb_config.svh"

module app_top
(
    input  wire                    CLK_IN,
    input  wire                    rst_n,

    // Master port
    input  wire lb_pkg::bus_adr_t  adr,
    input  wire                    wr,
    input  wire                    rd,
    input  wire lb_pkg::bus_dat_t  wr_dat,
    input  wire lb_pkg::bus_strb_t wr_strb,
    output wire lb_pkg::bus_dat_t  rd_dat,
    output wire                    rd_vld,

    // Parallel I/O
    input  wire periph_pkg::pio_dat_t pio_in,
    output periph_pkg::pio_dat_t      pio_out,

    // Timer interrupt
    output wire                    tmr_irq,

    // External local bus port
    output wire lb_pkg::port_adr_t ext_adr,
    output wire                    ext_wr,
    output wire                    ext_rd,
    output wire lb_pkg::bus_dat_t  ext_din,
    input  wire lb_pkg::bus_dat_t  ext_dout,
    input  wire                    ext_vld
);

    // RAM side
    lb_pkg::bus_dat_t ram_rd_dat;
    logic             ram_rd_vld;
    logic             lb_sel;

    // Upstream of mux uses the full local bus address
    lb_if #(.adr_t(lb_pkg::lb_adr_t)) lb_up ();
    lb_if lb_pio ();
    lb_if lb_tmr ();
    lb_if lb_ext ();

    // Bit 31 picks the local bus
    assign lb_sel = adr[31];

    data_ram data_ram_i
    (
        .CLK_IN  (CLK_IN),
        .rst_n   (rst_n),
        .adr     (adr[`RAM_ADR_WIDTH+1:2]),
        .wr      (wr && !lb_sel),
        .rd      (rd && !lb_sel),
        .wr_dat  (wr_dat),
        .wr_strb (wr_strb),
        .rd_dat  (ram_rd_dat),
        .rd_vld  (ram_rd_vld)
    );

    // Word address from byte address, strobes ignored on local bus
    assign lb_up.adr = adr[`LB_ADR_WIDTH+1:2];
    assign lb_up.wr  = wr && lb_sel;
    assign lb_up.rd  = rd && lb_sel;
    assign lb_up.din = wr_dat;

    lb_mux lb_mux_i
    (
        .CLK_IN (CLK_IN),
        .rst_n  (rst_n),
        .up     (lb_up),
        .dn0    (lb_pio),
        .dn1    (lb_tmr),
        .dn2    (lb_ext)
    );

    pio pio_i
    (
        .CLK_IN  (CLK_IN),
        .rst_n   (rst_n),
        .lb      (lb_pio),
        .pio_in  (pio_in),
        .pio_out (pio_out)
    );

    tmr tmr_i
    (
        .CLK_IN (CLK_IN),
        .rst_n  (rst_n),
        .lb     (lb_tmr),
        .irq    (tmr_irq)
    );

    // Port 2 goes straight to the pins
    assign ext_adr     = lb_ext.adr;
    assign ext_wr      = lb_ext.wr;
    assign ext_rd      = lb_ext.rd;
    assign ext_din     = lb_ext.din;
    assign lb_ext.dout = ext_dout;
    assign lb_ext.vld  = ext_vld;

    // Local bus data wins when it answers
    assign rd_dat = lb_up.vld ? lb_up.dout : ram_rd_dat;
    assign rd_vld = lb_up.vld || ram_rd_vld;

endmodule

`default_nettype wire

// File: src/data_ram.sv
// Single port data RAM with byte lane writes and a one cycle registered read
`default_nettype none
`timescale 1ns/1ps

`include "lb_config.svh"

module data_ram
(
    input  wire                    CLK_IN,
    input  wire                    rst_n,
    input  wire lb_pkg::ram_adr_t  adr,
    input  wire                    wr,
    input  wire                    rd,
    input  wire lb_pkg::bus_dat_t  wr_dat,
    input  wire lb_pkg::bus_strb_t wr_strb,
    output lb_pkg::bus_dat_t       rd_dat,
    output logic                   rd_vld
);

    // Word array, upper master address bits already dropped
    lb_pkg::bus_dat_t mem [2**`RAM_ADR_WIDTH];

    // Byte lane writes and registered read
    always_ff @(posedge CLK_IN)
    begin
        if (wr)
        begin
            for (int i = 0; i < `LB_DAT_WIDTH/8; i++)
            begin
                if (wr_strb[i])
                    mem[adr][8*i +: 8] <= wr_dat[8*i +: 8];
            end
        end
        if (rd)
            rd_dat <= mem[adr];
    end

    // Valid follows rd by one cycle
    always_ff @(posedge CLK_IN)
    begin
        if (!rst_n)
            rd_vld <= 1'b0;
        else
            rd_vld <= rd;
    end

endmodule

`default_nettype wire

// File: src/lb_mux.sv
// Local bus multiplexer: routes strobes to one of four ports and returns the answering data
`default_nettype none
`timescale 1ns/1ps

`include "lb_config.svh"

module lb_mux
(
    input  wire  CLK_IN,
    input  wire  rst_n,

    // From the top, full local bus address
    lb_if.slave  up,

    // Port 0 PIO, port 1 timer, port 2 external
    lb_if.master dn0,
    lb_if.master dn1,
    lb_if.master dn2
);

    logic [1:0] sel;
    // Answer for the unmapped port 3
    logic       unm_vld;

    // Two top address bits pick the port
    assign sel = up.adr[`LB_ADR_WIDTH-1 -: 2];

    // Port address and write data go to all ports
    assign dn0.adr = up.adr[`LB_ADR_WIDTH-3:0];
    assign dn1.adr = up.adr[`LB_ADR_WIDTH-3:0];
    assign dn2.adr = up.adr[`LB_ADR_WIDTH-3:0];
    assign dn0.din = up.din;
    assign dn1.din = up.din;
    assign dn2.din = up.din;

    // Strobes only to the selected port
    assign dn0.wr = up.wr && (sel == 2'd0);
    assign dn0.rd = up.rd && (sel == 2'd0);
    assign dn1.wr = up.wr && (sel == 2'd1);
    assign dn1.rd = up.rd && (sel == 2'd1);
    assign dn2.wr = up.wr && (sel == 2'd2);
    assign dn2.rd = up.rd && (sel == 2'd2);

    // Port 3 has nothing behind it, answer ourselves so the master never hangs
    always_ff @(posedge CLK_IN)
    begin
        if (!rst_n)
            unm_vld <= 1'b0;
        else
            unm_vld <= up.rd && (sel == 2'd3);
    end

    // At most one port answers in a cycle
    always_comb
    begin
        if (dn0.vld)
            up.dout = dn0.dout;
        else if (dn1.vld)
            up.dout = dn1.dout;
        else if (dn2.vld)
            up.dout = dn2.dout;
        else
            // Unmapped reads and idle cycles return zero
            up.dout = '0;
    end

    assign up.vld = dn0.vld || dn1.vld || dn2.vld || unm_vld;

endmodule

`default_nettype wire

// File: src/pio.sv
// Parallel I/O block on the local bus: version, output register with set/clear, synced input
`default_nettype none
`timescale 1ns/1ps

`include "lb_config.svh"

module pio
(
    input  wire                       CLK_IN,
    input  wire                       rst_n,
    lb_if.slave                       lb,
    input  wire periph_pkg::pio_dat_t pio_in,
    output periph_pkg::pio_dat_t      pio_out
);

    // Two flop synchronizer on the inputs
    periph_pkg::pio_dat_t in_meta;
    periph_pkg::pio_dat_t in_sync;

    always_ff @(posedge CLK_IN)
    begin
        in_meta <= pio_in;
        in_sync <= in_meta;
    end

    // Output register
    always_ff @(posedge CLK_IN)
    begin
        if (!rst_n)
            pio_out <= '0;
        else if (lb.wr)
        begin
            case (lb.adr)
                periph_pkg::PIO_OUT : pio_out <= lb.din[`PIO_WIDTH-1:0];
                periph_pkg::PIO_SET : pio_out <= pio_out | lb.din[`PIO_WIDTH-1:0];
                periph_pkg::PIO_CLR : pio_out <= pio_out & ~lb.din[`PIO_WIDTH-1:0];
                default : ;
            endcase
        end
    end

    // Read data, registered
    always_ff @(posedge CLK_IN)
    begin
        if (lb.rd)
        begin
            case (lb.adr)
                periph_pkg::PIO_VERSION :
                    lb.dout <= {16'h0, 8'(`HW_VER_MAJOR), 8'(`HW_VER_MINOR)};
                periph_pkg::PIO_OUT : lb.dout <= `LB_DAT_WIDTH'(pio_out);
                periph_pkg::PIO_IN  : lb.dout <= `LB_DAT_WIDTH'(in_sync);
                default             : lb.dout <= '0;
            endcase
        end
    end

    // Every read answered one cycle later
    always_ff @(posedge CLK_IN)
    begin
        if (!rst_n)
            lb.vld <= 1'b0;
        else
            lb.vld <= lb.rd;
    end

endmodule

`default_nettype wire

// File: src/tmr.sv
// Prescaled periodic timer on the local bus with a pending flag and a maskable interrupt
`default_nettype none
`timescale 1ns/1ps

`include "lb_config.svh"

module tmr
(
    input  wire CLK_IN,
    input  wire rst_n,
    lb_if.slave lb,
    output logic irq
);

    // CTL bits
    localparam int CTL_EN = 0;
    localparam int CTL_IE = 1;
    localparam int PRE_WIDTH = $clog2(`TMR_BEAT);

    logic [1:0]           ctl;
    periph_pkg::tmr_cnt_t period;
    periph_pkg::tmr_cnt_t cnt;
    logic                 pend;
    logic [PRE_WIDTH-1:0] pre;
    logic                 tick;

    // Prescaler held at zero while disabled
    assign tick = ctl[CTL_EN] && (pre == PRE_WIDTH'(`TMR_BEAT - 1));

    always_ff @(posedge CLK_IN)
    begin
        if (!rst_n)
            pre <= '0;
        else if (!ctl[CTL_EN] || tick)
            pre <= '0;
        else
            pre <= pre + 1'b1;
    end

    // Compare value for the count
    always_ff @(posedge CLK_IN)
    begin
        if (lb.wr && (lb.adr == periph_pkg::TMR_PERIOD))
            period <= lb.din;
    end

    // Control, count and pending flag
    always_ff @(posedge CLK_IN)
    begin
        if (!rst_n)
        begin
            ctl  <= '0;
            cnt  <= '0;
            pend <= 1'b0;
        end
        else
        begin
            if (lb.wr && (lb.adr == periph_pkg::TMR_CTL))
                ctl <= lb.din[1:0];
            // Write one to clear
            if (lb.wr && (lb.adr == periph_pkg::TMR_STA) && lb.din[0])
                pend <= 1'b0;
            if (tick)
            begin
                if (cnt == period)
                begin
                    cnt  <= '0;
                    // A new event beats a clear in the same cycle
                    pend <= 1'b1;
                end
                else
                    cnt <= cnt + 1'b1;
            end
        end
    end

    // Registered interrupt
    always_ff @(posedge CLK_IN)
    begin
        if (!rst_n)
            irq <= 1'b0;
        else
            irq <= pend && ctl[CTL_IE];
    end

    // Read data and valid
    always_ff @(posedge CLK_IN)
    begin
        if (lb.rd)
        begin
            case (lb.adr)
                periph_pkg::TMR_CTL    : lb.dout <= `LB_DAT_WIDTH'(ctl);
                periph_pkg::TMR_PERIOD : lb.dout <= period;
                periph_pkg::TMR_COUNT  : lb.dout <= cnt;
                periph_pkg::TMR_STA    : lb.dout <= `LB_DAT_WIDTH'(pend);
                default                : lb.dout <= '0;
            endcase
        end
    end

    always_ff @(posedge CLK_IN)
    begin
        if (!rst_n)
            lb.vld <= 1'b0;
        else
            lb.vld <= lb.rd;
    end

endmodule

`default_nettype wire

// File: testbench/app_cases.txt
# op address data strobes, all hex; W write, R read with expected data in the data column
# P sets pio_in, O checks pio_out, I waits for tmr_irq level, N idles n cycles (value in address column)
# RAM full words, then byte lanes merged with the old contents
W 00000000 11223344 f
W 00000004 aabbccdd f
W 00000008 cafef00d f
W 00000000 000000ee 1
W 00000004 55660000 c
W 00000008 00abcd00 6
R 00000000 112233ee
R 00000004 5566ccdd
R 00000008 caabcd0d
# PIO version, out, set, clear, synced input
R 80000000 00000100
W 80000004 0000a5a5 f
O 0000a5a5
R 80000004 0000a5a5
W 8000000c 00000f00 f
O 0000afa5
W 80000010 000000a5 f
O 0000af00
P 00001234
N 3
R 80000008 00001234
# Timer count holds while disabled, then period 3 with irq enable
W 80040004 00000003 f
R 80040008 00000000
N 4
R 80040008 00000000
W 80040000 00000003 f
I 1
R 8004000c 00000001
W 8004000c 00000001 f
I 0
W 80040000 00000000 f
# External port, data column ignored on reads
R 80080010 00000000
R 80080014 00000000
W 80080020 12345678 f
# Unmapped port reads zero and its writes reach no register
R 800c0000 00000000
W 800c0004 0000ffff f
W 800c0000 00000003 f
O 0000af00
R 80040000 00000000
R 80040004 00000003
# Mixed back to back reads over all paths
R 00000000 112233ee
R 80000000 00000100
R 80080040 00000000
R 800c0008 00000000

// File: testbench/app_checker.sv
// Testbench checker: compares read data, PIO output, timer interrupt and external writes
`default_nettype none
`timescale 1ns/1ps

module app_checker
#(
    parameter lb_pkg::bus_dat_t EXT_TAG = '0
)
(
    input wire                       CLK_IN,
    input wire                       rst_n,
    input wire                       rd,
    input wire                       rd_vld,
    input wire lb_pkg::bus_dat_t     rd_dat,
    input wire periph_pkg::pio_dat_t pio_out,
    input wire                       tmr_irq,
    input wire                       ext_wr,
    input wire lb_pkg::port_adr_t    ext_adr,
    input wire lb_pkg::bus_dat_t     ext_din
);

    localparam int IRQ_TIMEOUT = 200;

    // Expected read data in issue order
    lb_pkg::bus_dat_t  exp_q [$];
    // Expected external writes
    lb_pkg::port_adr_t wr_adr_q [$];
    lb_pkg::bus_dat_t  wr_dat_q [$];
    logic              rd_q;
    int                value_errs = 0;
    int                other_errs = 0;
    int                reads_seen = 0;

    task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] got);
        $display("ERR %0t %s expected %08h got %08h", $time, name, exp, got);
        value_errs++;
    endtask

    task automatic report_failure(input string msg);
        $display("%0t %s", $time, msg);
        other_errs++;
    endtask

    task automatic expect_read(input lb_pkg::bus_dat_t exp);
        exp_q.push_back(exp);
    endtask

    // Same rule the external responder follows
    task automatic expect_ext_read(input lb_pkg::port_adr_t a);
        exp_q.push_back(EXT_TAG ^ lb_pkg::bus_dat_t'(a));
    endtask

    task automatic expect_ext_write(input lb_pkg::port_adr_t a, input lb_pkg::bus_dat_t d);
        wr_adr_q.push_back(a);
        wr_dat_q.push_back(d);
    endtask

    task automatic check_pio_out(input periph_pkg::pio_dat_t exp);
        if (pio_out !== exp)
            value_error("pio_out", 32'(exp), 32'(pio_out));
    endtask

    task automatic wait_irq(input logic level);
        int cycles;
        cycles = 0;
        while (tmr_irq !== level && cycles < IRQ_TIMEOUT)
        begin
            @(posedge CLK_IN);
            cycles++;
        end
        if (tmr_irq !== level)
            report_failure($sformatf("tmr_irq did not go to %0d within %0d cycles",
                                     level, IRQ_TIMEOUT));
    endtask

    function automatic int outstanding();
        return exp_q.size() + wr_adr_q.size();
    endfunction

    function automatic int error_total();
        return value_errs + other_errs;
    endfunction

    task automatic print_summary();
        $display("checker: %0d reads, %0d value errors, %0d other errors",
                 reads_seen, value_errs, other_errs);
    endtask

    // Sampled on the rising edge, all DUT outputs settled by then
    always @(posedge CLK_IN)
    begin : compare
        lb_pkg::bus_dat_t  exp;
        lb_pkg::port_adr_t ea;
        lb_pkg::bus_dat_t  ed;
        if (!rst_n)
            rd_q <= 1'b0;
        else
        begin
            rd_q <= rd;
            // rd_vld must follow rd by exactly one cycle
            if (rd_q && !rd_vld)
            begin
                report_failure("read valid did not arrive one cycle after the read strobe");
                if (exp_q.size() != 0)
                    void'(exp_q.pop_front());
            end
            if (rd_vld && !rd_q)
                report_failure("read valid arrived without a read one cycle before");
            if (rd_vld)
            begin
                reads_seen++;
                if (exp_q.size() == 0)
                    report_failure("read data arrived with no expected value queued");
                else
                begin
                    exp = exp_q.pop_front();
                    if (rd_dat !== exp)
                        value_error("rd_dat", exp, rd_dat);
                end
            end
            // External writes must match the queued address and data
            if (ext_wr)
            begin
                if (wr_adr_q.size() == 0)
                    report_failure("unexpected write on the external port");
                else
                begin
                    ea = wr_adr_q.pop_front();
                    ed = wr_dat_q.pop_front();
                    if (ext_adr !== ea)
                        value_error("ext_adr", 32'(ea), 32'(ext_adr));
                    if (ext_din !== ed)
                        value_error("ext_din", ed, ext_din);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/app_top_tb.sv
// Testbench top that runs the case file and a random RAM phase and answers the external port
`default_nettype none
`timescale 1ns/1ps

module app_top_tb;

    // Half period in ns
    localparam int CLK_HALF = 50;
    localparam int RST_CYCLES = 5;
    localparam int DRAIN_TIMEOUT = 20;
    localparam int RAND_WORDS = 16;
    // External port answers with this tag XOR the port address
    localparam lb_pkg::bus_dat_t EXT_TAG = 32'h5a00_0000;

    logic                 CLK_IN;
    logic                 rst_n;
    lb_pkg::bus_adr_t     adr;
    logic                 wr;
    logic                 rd;
    lb_pkg::bus_dat_t     wr_dat;
    lb_pkg::bus_strb_t    wr_strb;
    lb_pkg::bus_dat_t     rd_dat;
    logic                 rd_vld;
    periph_pkg::pio_dat_t pio_in;
    periph_pkg::pio_dat_t pio_out;
    logic                 tmr_irq;
    lb_pkg::port_adr_t    ext_adr;
    logic                 ext_wr;
    logic                 ext_rd;
    lb_pkg::bus_dat_t     ext_din;
    lb_pkg::bus_dat_t     ext_dout = '0;
    logic                 ext_vld = 1'b0;

    // Responder pipeline
    logic                 ext_rd_q;
    lb_pkg::port_adr_t    ext_adr_q;

    integer seed;

    app_top app_top_i
    (
        .CLK_IN   (CLK_IN),
        .rst_n    (rst_n),
        .adr      (adr),
        .wr       (wr),
        .rd       (rd),
        .wr_dat   (wr_dat),
        .wr_strb  (wr_strb),
        .rd_dat   (rd_dat),
        .rd_vld   (rd_vld),
        .pio_in   (pio_in),
        .pio_out  (pio_out),
        .tmr_irq  (tmr_irq),
        .ext_adr  (ext_adr),
        .ext_wr   (ext_wr),
        .ext_rd   (ext_rd),
        .ext_din  (ext_din),
        .ext_dout (ext_dout),
        .ext_vld  (ext_vld)
    );

    app_checker #(.EXT_TAG(EXT_TAG)) checker_i
    (
        .CLK_IN  (CLK_IN),
        .rst_n   (rst_n),
        .rd      (rd),
        .rd_vld  (rd_vld),
        .rd_dat  (rd_dat),
        .pio_out (pio_out),
        .tmr_irq (tmr_irq),
        .ext_wr  (ext_wr),
        .ext_adr (ext_adr),
        .ext_din (ext_din)
    );

    always
    begin
        #CLK_HALF CLK_IN = ~CLK_IN;
    end

    // External responder captures on the rise and answers from the next fall
    always @(posedge CLK_IN)
    begin
        ext_rd_q  <= ext_rd;
        ext_adr_q <= ext_adr;
    end

    always @(negedge CLK_IN)
    begin
        ext_vld  <= ext_rd_q;
        ext_dout <= ext_rd_q ? (EXT_TAG ^ lb_pkg::bus_dat_t'(ext_adr_q)) : '0;
    end

    // Bit 31 set and port select 2
    function automatic bit is_ext(input lb_pkg::bus_adr_t a);
        return a[31] && (a[19:18] == 2'd2);
    endfunction

    // One bus cycle driven on the falling edge
    task automatic drive_cycle(input logic w, input logic r, input lb_pkg::bus_adr_t a,
                               input lb_pkg::bus_dat_t d, input lb_pkg::bus_strb_t s);
        @(negedge CLK_IN);
        wr      = w;
        rd      = r;
        adr     = a;
        wr_dat  = d;
        wr_strb = s;
    endtask

    task automatic idle(input int n);
        repeat (n) drive_cycle(1'b0, 1'b0, '0, '0, '0);
    endtask

    task automatic bus_write(input lb_pkg::bus_adr_t a, input lb_pkg::bus_dat_t d,
                             input lb_pkg::bus_strb_t s);
        if (is_ext(a))
            checker_i.expect_ext_write(a[17:2], d);
        drive_cycle(1'b1, 1'b0, a, d, s);
    endtask

    // External reads get their expectation from the checker
    task automatic bus_read(input lb_pkg::bus_adr_t a, input lb_pkg::bus_dat_t exp);
        if (is_ext(a))
            checker_i.expect_ext_read(a[17:2]);
        else
            checker_i.expect_read(exp);
        drive_cycle(1'b0, 1'b1, a, '0, '0);
    endtask

    task automatic run_cases();
        int          fd;
        int          cnt;
        string       line;
        byte         op;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] s;
        fd = $fopen("testbench/app_cases.txt", "r");
        if (fd == 0)
        begin
            checker_i.report_failure("case file testbench/app_cases.txt could not be opened");
            return;
        end
        while ($fgets(line, fd) != 0)
        begin
            op  = "#";
            cnt = $sscanf(line, "%c %h %h %h", op, a, d, s);
            // Every operation needs at least its address column
            if (cnt == 1 && op >= "A" && op <= "Z")
            begin
                checker_i.report_failure({"case file line without operands: ", line});
                op = "#";
            end
            case (op)
                "W" : bus_write(a, d, s[3:0]);
                "R" : bus_read(a, d);
                "P" :
                begin
                    idle(1);
                    pio_in = a[15:0];
                end
                "O" :
                begin
                    idle(1);
                    checker_i.check_pio_out(a[15:0]);
                end
                "I" :
                begin
                    idle(1);
                    checker_i.wait_irq(a[0]);
                end
                "N" : idle(a);
                // Comments and blank lines
                "#", "\n", "\r", " " : ;
                default : checker_i.report_failure({"unknown case file line: ", line});
            endcase
        end
        $fclose(fd);
    endtask

    // Full word writes to random RAM words followed by back to back reads
    task automatic run_random();
        lb_pkg::bus_adr_t adrs [RAND_WORDS];
        lb_pkg::bus_dat_t datas [RAND_WORDS];
        lb_pkg::bus_dat_t exp;
        for (int i = 0; i < RAND_WORDS; i++)
        begin
            adrs[i]  = {20'h0, 10'($random(seed)), 2'b00};
            datas[i] = $random(seed);
            bus_write(adrs[i], datas[i], 4'hf);
        end
        for (int i = 0; i < RAND_WORDS; i++)
        begin
            exp = datas[i];
            // A later write to the same word holds the final value
            for (int j = i + 1; j < RAND_WORDS; j++)
            begin
                if (adrs[j] == adrs[i])
                    exp = datas[j];
            end
            bus_read(adrs[i], exp);
        end
    endtask

    initial
    begin
        int waited;
        CLK_IN  = 1'b0;
        rst_n   = 1'b0;
        adr     = '0;
        wr      = 1'b0;
        rd      = 1'b0;
        wr_dat  = '0;
        wr_strb = '0;
        pio_in  = '0;
        seed    = 32'h7987;
        repeat (RST_CYCLES) @(negedge CLK_IN);
        rst_n = 1'b1;
        run_cases();
        run_random();
        idle(1);
        // Let the last answers come back
        waited = 0;
        while (checker_i.outstanding() != 0 && waited < DRAIN_TIMEOUT)
        begin
            @(negedge CLK_IN);
            waited++;
        end
        if (checker_i.outstanding() != 0)
            checker_i.report_failure("expected reads or external writes never arrived");
        checker_i.print_summary();
        if (checker_i.error_total() == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire
